/* hw/ahbl_sys_pkg.sv */
// ##########################################################################
// Shared bus types, address map and register offsets of the AHB-Lite
// slave subsystem. Only the top address byte selects a slave.
// hburst, hprot and hmastlock are not carried; only NONSEQ transfers
// are recognised, SEQ and BUSY count as idle.
// ##########################################################################

`default_nettype none

package ahbl_sys_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int ADDR_TOP_W = 8;   // Decoded top address bits
    localparam int SRAM_AW    = 11;  // 2K words, 8 KB
    localparam int REG_OFF_W  = 8;   // Register decode width

    // Slot indices of the splitter
    localparam int SLOT_SRAM   = 0;
    localparam int SLOT_BRIDGE = 1;
    localparam int SLOT_REGS   = 2;
    localparam int NUM_SLOTS   = 3;

    localparam logic [ADDR_TOP_W-1:0] SRAM_BASE   = 8'h20;
    localparam logic [ADDR_TOP_W-1:0] BRIDGE_BASE = 8'h26; // Housekeeping bridge
    localparam logic [ADDR_TOP_W-1:0] REGS_BASE   = 8'h27;

    localparam logic [REG_OFF_W-1:0] REG_VREF     = 8'h00;
    localparam logic [REG_OFF_W-1:0] REG_MUXSPLIT = 8'h04;
    localparam logic [REG_OFF_W-1:0] REG_USER     = 8'h08;
    localparam logic [REG_OFF_W-1:0] REG_SIO      = 8'h0C;
    localparam logic [REG_OFF_W-1:0] REG_STATUS   = 8'h10; // Read only

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // Master to slave, hwdata is the only data phase field
    typedef struct packed {
        logic [ADDR_W-1:0] haddr;
        logic [1:0]        htrans;
        logic              hwrite;
        logic [2:0]        hsize;
        logic              hready;
        logic [DATA_W-1:0] hwdata;
    } ahbl_req_t;

    typedef struct packed {
        logic              hready_resp;
        logic              hresp;
        logic [DATA_W-1:0] hrdata;
    } ahbl_rsp_t;

    typedef struct packed {
        logic               en;
        logic               r_wb;  // 1 reads
        logic [SRAM_AW-1:0] addr;
        logic [DATA_W-1:0]  wdata;
        logic [DATA_W-1:0]  ben;   // Bit enables
    } sram_port_t;

    // Switches of one corner, aa_sl is the MSB
    typedef struct packed {
        logic aa_sl;
        logic aa_s0;
        logic bb_s0;
        logic bb_sl;
        logic bb_sr;
        logic aa_sr;
    } mux_corner_t;

    // se sits in bits 23:18, nw in bits 5:0
    typedef struct packed {
        mux_corner_t se;
        mux_corner_t sw;
        mux_corner_t ne;
        mux_corner_t nw;
    } muxsplit_t;

    typedef struct packed {
        logic        vref_e_en;
        logic        vref_w_en;
        logic [4:0]  vref_e_sel;
        logic [4:0]  vref_w_sel;
        muxsplit_t   muxsplit;
        logic        user_ahb_enable;
        logic [15:0] user_irqs_enable;
        logic [5:0]  sio_cfg;
    } sys_cfg_t;

endpackage

`default_nettype wire

/* hw/ahbl_splitter.sv */
// ##########################################################################
// AHB-Lite address splitter for NUM_SLOTS slaves, decoded on the top
// address byte. Adds no wait states of its own.
// Addresses that match no slot get a two cycle ERROR response.
// The master is expected to hold its address phase while stalled.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module ahbl_splitter
    import ahbl_sys_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  ahbl_req_t src_req,
    output ahbl_rsp_t src_rsp,
    output ahbl_req_t dst_req [NUM_SLOTS],
    input  ahbl_rsp_t dst_rsp [NUM_SLOTS]
);

    logic [ADDR_TOP_W-1:0] addr_top;
    logic                  addr_active;
    logic                  bus_ready;
    logic [NUM_SLOTS-1:0]  sel_hit;
    logic [NUM_SLOTS-1:0]  dp_sel;    // One-hot, zero when no slot owns the data phase
    logic                  dp_err;
    logic                  err_done;  // Second cycle of the error response

    assign addr_top    = src_req.haddr[ADDR_W-1 -: ADDR_TOP_W];
    assign addr_active = (src_req.htrans == HTRANS_NONSEQ);
    assign bus_ready   = src_req.hready & src_rsp.hready_resp;

    // Address decode
    always_comb begin
        sel_hit = '0;
        sel_hit[SLOT_SRAM]   = (addr_top == SRAM_BASE);
        sel_hit[SLOT_BRIDGE] = (addr_top == BRIDGE_BASE);
        sel_hit[SLOT_REGS]   = (addr_top == REGS_BASE);
    end

    // Request fan-out, unselected slots only ever see IDLE
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            dst_req[i]        = src_req;
            dst_req[i].hready = src_rsp.hready_resp;
            if (!sel_hit[i]) begin
                dst_req[i].htrans = HTRANS_IDLE;
            end
        end
    end

    // Data phase owner
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dp_sel   <= '0;
            dp_err   <= 1'b0;
            err_done <= 1'b0;
        end else if (bus_ready) begin
            dp_sel   <= addr_active ? sel_hit : '0;
            dp_err   <= addr_active && (sel_hit == '0);
            err_done <= 1'b0;
        end else if (dp_err) begin
            err_done <= 1'b1;
        end
    end

    // Response mux
    always_comb begin
        src_rsp = '{hready_resp: 1'b1, hresp: 1'b0, hrdata: '0};
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (dp_sel[i]) begin
                src_rsp = dst_rsp[i];
            end
        end
        // Default slave, ERROR with one stall cycle then one ready cycle
        if (dp_err) begin
            src_rsp.hready_resp = err_done;
            src_rsp.hresp       = 1'b1;
            src_rsp.hrdata      = '0;
        end
    end

endmodule

`default_nettype wire

/* hw/ahbl_sram_ctrl.sv */
// ##########################################################################
// AHB-Lite slave for a single-port SRAM macro with bit enables and a
// one cycle read. Writes land in the data phase; a read that meets a
// write data phase waits one cycle. The SRAM window aliases every
// 8 KB within its slot. Transfers wider than 32 bits are not supported.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module ahbl_sram_ctrl
    import ahbl_sys_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  ahbl_req_t         req,
    output ahbl_rsp_t         rsp,
    output sram_port_t        sram,
    input  logic [DATA_W-1:0] sram_rdata
);

    logic               ap_valid;
    logic               ap_read;
    logic               wr_pend;  // Write data phase, macro busy
    logic               rd_wait;  // Read delayed behind a write
    logic               rd_dp;    // Macro output belongs to the current read
    logic [SRAM_AW-1:0] a_addr;
    logic [1:0]         a_size;
    logic [1:0]         a_off;
    logic [3:0]         lanes;

    assign ap_valid = req.hready && (req.htrans == HTRANS_NONSEQ);
    assign ap_read  = ap_valid && !req.hwrite;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_pend <= 1'b0;
            rd_wait <= 1'b0;
            rd_dp   <= 1'b0;
        end else begin
            wr_pend <= ap_valid && req.hwrite;
            rd_wait <= ap_read && wr_pend;
            rd_dp   <= (ap_read && !wr_pend) || rd_wait;
        end
    end

    // Address phase capture, used by delayed writes and reads
    always_ff @(posedge clk) begin
        if (ap_valid) begin
            a_addr <= req.haddr[SRAM_AW+1:2];
            a_size <= req.hsize[1:0];
            a_off  <= req.haddr[1:0];
        end
    end

    // Byte lanes from size and offset
    always_comb begin
        case (a_size)
            2'd0:    lanes = 4'b0001 << a_off;
            2'd1:    lanes = a_off[1] ? 4'b1100 : 4'b0011;
            default: lanes = 4'b1111;
        endcase
    end

    always_comb begin
        sram.en    = 1'b0;
        sram.r_wb  = 1'b1;
        sram.addr  = a_addr;
        sram.wdata = req.hwdata;
        for (int i = 0; i < 4; i++) begin
            sram.ben[8*i +: 8] = {8{lanes[i] & wr_pend}};
        end
        if (wr_pend) begin
            sram.en   = 1'b1;
            sram.r_wb = 1'b0;
        end else if (rd_wait) begin
            sram.en = 1'b1;            // Replay the held read
        end else if (ap_read) begin
            sram.en   = 1'b1;
            sram.addr = req.haddr[SRAM_AW+1:2];
        end
    end

    assign rsp.hready_resp = !rd_wait;
    assign rsp.hresp       = 1'b0;
    assign rsp.hrdata      = rd_dp ? sram_rdata : '0;

endmodule

`default_nettype wire

/* hw/sys_regs.sv */
// ##########################################################################
// System configuration registers, zero wait states, never ERROR.
// Writes are always full words, hsize is ignored.
// Only the low offset byte is decoded, so the block aliases in its slot.
// Unknown offsets read zero and drop writes.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module sys_regs
    import ahbl_sys_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  ahbl_req_t req,
    output ahbl_rsp_t rsp,
    input  logic      mgmt_select,
    output sys_cfg_t  cfg
);

    logic                 ap_valid;
    logic                 dp_wr;
    logic [REG_OFF_W-1:0] dp_off;
    logic [DATA_W-1:0]    rd_data;

    assign ap_valid = req.hready && (req.htrans == HTRANS_NONSEQ);

    // Address phase
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dp_wr  <= 1'b0;
            dp_off <= '0;
        end else begin
            dp_wr <= ap_valid && req.hwrite;
            if (ap_valid) begin
                dp_off <= req.haddr[REG_OFF_W-1:0];
            end
        end
    end

    // Data phase writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;
        end else if (dp_wr) begin
            case (dp_off)
                REG_VREF: begin
                    cfg.vref_e_en  <= req.hwdata[0];
                    cfg.vref_w_en  <= req.hwdata[1];
                    cfg.vref_e_sel <= req.hwdata[6:2];
                    cfg.vref_w_sel <= req.hwdata[11:7];
                end
                REG_MUXSPLIT: begin
                    cfg.muxsplit <= req.hwdata[23:0];
                end
                REG_USER: begin
                    cfg.user_ahb_enable  <= req.hwdata[0];
                    cfg.user_irqs_enable <= req.hwdata[31:16];
                end
                REG_SIO: begin
                    cfg.sio_cfg <= req.hwdata[5:0];
                end
                default: ;  // Status and holes
            endcase
        end
    end

    // Read mux, unused bits stay zero
    always_comb begin
        rd_data = '0;
        case (dp_off)
            REG_VREF: begin
                rd_data[0]    = cfg.vref_e_en;
                rd_data[1]    = cfg.vref_w_en;
                rd_data[6:2]  = cfg.vref_e_sel;
                rd_data[11:7] = cfg.vref_w_sel;
            end
            REG_MUXSPLIT: rd_data[23:0] = cfg.muxsplit;
            REG_USER: begin
                rd_data[0]     = cfg.user_ahb_enable;
                rd_data[31:16] = cfg.user_irqs_enable;
            end
            REG_SIO:    rd_data[5:0] = cfg.sio_cfg;
            REG_STATUS: rd_data[0]   = mgmt_select;
            default:    rd_data      = '0;
        endcase
    end

    assign rsp.hready_resp = 1'b1;
    assign rsp.hresp       = 1'b0;
    assign rsp.hrdata      = rd_data;

endmodule

`default_nettype wire

/* hw/ahbl_sys0.sv */
// ##########################################################################
// AHB-Lite slave subsystem: SRAM at 0x20, housekeeping bridge at 0x26,
// system registers at 0x27 (top address byte). Everything else ERRORs.
// The SRAM macro sits outside and runs on clk.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module ahbl_sys0
    import ahbl_sys_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  ahbl_req_t         ahb_req,
    output ahbl_rsp_t         ahb_rsp,
    output ahbl_req_t         ext_req,     // Housekeeping bridge
    input  ahbl_rsp_t         ext_rsp,
    output sram_port_t        sram,
    input  logic [DATA_W-1:0] sram_rdata,
    input  logic              mgmt_select,
    output sys_cfg_t          cfg
);

    ahbl_req_t slot_req [NUM_SLOTS];
    ahbl_rsp_t slot_rsp [NUM_SLOTS];

    ahbl_splitter u_splitter (
        .clk     (clk),
        .arst_n  (arst_n),
        .src_req (ahb_req),
        .src_rsp (ahb_rsp),
        .dst_req (slot_req),
        .dst_rsp (slot_rsp)
    );

    ahbl_sram_ctrl u_sram (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (slot_req[SLOT_SRAM]),
        .rsp        (slot_rsp[SLOT_SRAM]),
        .sram       (sram),
        .sram_rdata (sram_rdata)
    );

    // Bridge slot leaves the subsystem unchanged
    assign ext_req               = slot_req[SLOT_BRIDGE];
    assign slot_rsp[SLOT_BRIDGE] = ext_rsp;

    sys_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (slot_req[SLOT_REGS]),
        .rsp         (slot_rsp[SLOT_REGS]),
        .mgmt_select (mgmt_select),
        .cfg         (cfg)
    );

endmodule

`default_nettype wire

/* sim/sram_model.sv */
// ##########################################################################
// Behavioral single-port SRAM macro with bit enables.
// Read data appears half a cycle after the enable edge and holds until
// the next read. Contents start from an address-based fill pattern.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module sram_model
    import ahbl_sys_pkg::*;
(
    input  logic              clk,
    input  sram_port_t        sram,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0]  mem [2**SRAM_AW];
    logic [SRAM_AW-1:0] rd_addr;
    logic               rd_pend;

    initial begin
        for (int i = 0; i < 2**SRAM_AW; i++) begin
            mem[i] = {16'(i) ^ 16'hA5C3, ~16'(i)};  // Unique per word
        end
        rdata   = '0;
        rd_pend = 1'b0;
        rd_addr = '0;
    end

    always @(posedge clk) begin
        rd_pend <= sram.en && sram.r_wb;
        if (sram.en && sram.r_wb) begin
            rd_addr <= sram.addr;
        end else if (sram.en) begin
            mem[sram.addr] <= (mem[sram.addr] & ~sram.ben) | (sram.wdata & sram.ben);
        end
    end

    // Output moves on the falling edge
    always @(negedge clk) begin
        if (rd_pend) begin
            rdata = mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* sim/ahbl_sys0_tb.sv */
// ##########################################################################
// Directed testbench for the AHB-Lite slave subsystem. The master is
// pipelined. Each bus step drives one address phase and finishes the
// previous data phase. Read data is checked when its data phase ends.
// The first failing check stops the run.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module ahbl_sys0_tb
    import ahbl_sys_pkg::*;
;

    localparam int TIMEOUT_CYC = 32;

    logic              clk;
    logic              arst_n;
    logic              mgmt_select;
    ahbl_req_t         ahb_req;
    ahbl_rsp_t         ahb_rsp;
    ahbl_req_t         ext_req;
    ahbl_rsp_t         ext_rsp;
    sram_port_t        sram;
    logic [DATA_W-1:0] sram_rdata;
    sys_cfg_t          cfg;

    int    seed     = 31;  // Stimulus
    int    ext_seed = 31;  // Bridge wait states
    string tname    = "reset";

    // Transfer waiting for its data phase
    logic        pend_valid = 1'b0;
    logic        pend_write = 1'b0;
    logic        pend_err   = 1'b0;
    logic [31:0] pend_wdata = '0;
    logic [31:0] pend_exp   = '0;

    logic [31:0] sram_ref [2**SRAM_AW];

    ahbl_sys0 dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .ahb_req     (ahb_req),
        .ahb_rsp     (ahb_rsp),
        .ext_req     (ext_req),
        .ext_rsp     (ext_rsp),
        .sram        (sram),
        .sram_rdata  (sram_rdata),
        .mgmt_select (mgmt_select),
        .cfg         (cfg)
    );

    sram_model sram0 (
        .clk   (clk),
        .sram  (sram),
        .rdata (sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Housekeeping bridge model
    logic        ext_busy = 1'b0;
    logic        ext_wr   = 1'b0;
    logic [31:0] ext_addr = '0;
    int          ext_wait = 0;
    logic [31:0] ext_mem [16];

    always @(posedge clk) begin
        if (ext_busy && ext_rsp.hready_resp) begin
            ext_busy <= 1'b0;
            if (ext_wr) begin
                ext_mem[ext_addr[5:2]] <= ext_req.hwdata;
            end
        end else if (ext_busy) begin
            ext_wait <= ext_wait - 1;
        end
        if (ext_req.hready && ext_req.htrans == HTRANS_NONSEQ) begin
            ext_busy <= 1'b1;
            ext_addr <= ext_req.haddr;
            ext_wr   <= ext_req.hwrite;
            ext_wait <= $unsigned($random(ext_seed)) % 4;  // 0 to 3 stalls
        end
    end

    always @(negedge clk) begin
        ext_rsp.hready_resp = !ext_busy || (ext_wait == 0);
        ext_rsp.hresp       = 1'b0;
        ext_rsp.hrdata      = (ext_busy && !ext_wr) ? (ext_addr ^ 32'hA5A5_0000) : '0;
    end

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH %s %s: expected %0h, actual %0h", tname, what, exp, act);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    task automatic report_failure(input string msg);
        $display("%s in test %s", msg, tname);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    // Drives one address phase or IDLE and finishes the data phase in flight
    task automatic bus_step(input logic valid, input logic [31:0] addr, input logic write,
                            input logic [2:0] size, input logic [31:0] wdata,
                            input logic [31:0] exp, input logic err);
        int        cycles;
        ahbl_rsp_t first_rsp;
        cycles = 0;
        @(negedge clk);
        ahb_req.haddr  = addr;
        ahb_req.htrans = valid ? HTRANS_NONSEQ : HTRANS_IDLE;
        ahb_req.hwrite = write;
        ahb_req.hsize  = size;
        ahb_req.hwdata = pend_wdata;
        do begin
            if (cycles >= TIMEOUT_CYC) report_failure("No hready_resp from the bus");
            @(posedge clk);
            if (cycles == 0) first_rsp = ahb_rsp;
            cycles++;
        end while (!ahb_rsp.hready_resp);
        if (pend_valid && pend_err) begin
            assert (first_rsp.hresp && !first_rsp.hready_resp)
                else report_mismatch("error cycle 1 {ready,resp}", 2'b01,
                                     {first_rsp.hready_resp, first_rsp.hresp});
            assert (ahb_rsp.hresp) else report_mismatch("error cycle 2 hresp", 1, 0);
        end else if (pend_valid) begin
            assert (!ahb_rsp.hresp) else report_mismatch("hresp", 0, 1);
            if (!pend_write) begin
                assert (ahb_rsp.hrdata == pend_exp)
                    else report_mismatch("hrdata", pend_exp, ahb_rsp.hrdata);
            end
        end
        pend_valid = valid;
        pend_write = write;
        pend_err   = err;
        pend_wdata = wdata;
        pend_exp   = exp;
    endtask

    task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        bus_step(1'b1, addr, 1'b1, size, data, '0, 1'b0);
    endtask

    task automatic ahb_read(input logic [31:0] addr, input logic [31:0] exp);
        bus_step(1'b1, addr, 1'b0, 3'd2, '0, exp, 1'b0);
    endtask

    task automatic ahb_read_err(input logic [31:0] addr);
        bus_step(1'b1, addr, 1'b0, 3'd2, '0, '0, 1'b1);
    endtask

    task automatic bus_idle();
        bus_step(1'b0, '0, 1'b0, 3'd0, '0, '0, 1'b0);
    endtask

    function automatic logic [31:0] sram_addr(input logic [SRAM_AW-1:0] word);
        return {SRAM_BASE, {(22 - SRAM_AW){1'b0}}, word, 2'b00};
    endfunction

    // Bytes off to off+nbytes-1 come from data and the others stay
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                                input int nbytes, input int off);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (b >= off && b < off + nbytes) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic test_sram_words();
        logic [SRAM_AW-1:0] waddr [16];
        logic [31:0]        wdata;
        int                 j;
        tname = "sram_words";
        for (int i = 0; i < 16; i++) begin
            waddr[i] = SRAM_AW'($random(seed));
            wdata    = $random(seed);
            sram_ref[waddr[i]] = wdata;
            ahb_write(sram_addr(waddr[i]), 3'd2, wdata);
            j = $unsigned($random(seed)) % (i + 1);  // Any address written so far
            ahb_read(sram_addr(waddr[j]), sram_ref[waddr[j]]);
        end
        bus_idle();
    endtask

    task automatic test_sram_lanes();
        logic [31:0] addr;
        logic [31:0] exp;
        logic [31:0] data;
        tname = "sram_lanes";
        addr  = sram_addr(11'h123);
        exp   = $random(seed);
        ahb_write(addr, 3'd2, exp);
        ahb_read(addr, exp);
        for (int off = 0; off < 4; off++) begin
            data = $random(seed);  // All lanes driven but only one may land
            exp  = merge_lanes(exp, data, 1, off);
            ahb_write(addr | 32'(off), 3'd0, data);
            ahb_read(addr, exp);
        end
        for (int off = 0; off < 4; off += 2) begin
            data = $random(seed);
            exp  = merge_lanes(exp, data, 2, off);
            ahb_write(addr | 32'(off), 3'd1, data);
            ahb_read(addr, exp);
        end
        bus_idle();
    endtask

    task automatic test_sys_regs();
        logic [7:0]  offs [4] = '{REG_VREF, REG_MUXSPLIT, REG_USER, REG_SIO};
        logic [31:0] mask [4] = '{32'h0000_0FFF, 32'h00FF_FFFF, 32'hFFFF_0001, 32'h0000_003F};
        logic [31:0] d [4];
        sys_cfg_t    exp_cfg;
        tname = "sys_regs";
        for (int i = 0; i < 4; i++) ahb_read({REGS_BASE, 16'h0, offs[i]}, '0);
        ahb_read({REGS_BASE, 16'h0, REG_STATUS}, '0);
        bus_idle();
        @(negedge clk);
        assert (cfg == '0) else report_mismatch("cfg after reset", '0, cfg);
        for (int i = 0; i < 4; i++) begin
            d[i] = $random(seed);
            ahb_write({REGS_BASE, 16'h0, offs[i]}, 3'd2, d[i]);
        end
        for (int i = 0; i < 4; i++) ahb_read({REGS_BASE, 16'h0, offs[i]}, d[i] & mask[i]);
        bus_idle();
        exp_cfg                  = '0;
        exp_cfg.vref_e_en        = d[0][0];
        exp_cfg.vref_w_en        = d[0][1];
        exp_cfg.vref_e_sel       = d[0][6:2];
        exp_cfg.vref_w_sel       = d[0][11:7];
        exp_cfg.muxsplit         = d[1][23:0];
        exp_cfg.user_ahb_enable  = d[2][0];
        exp_cfg.user_irqs_enable = d[2][31:16];
        exp_cfg.sio_cfg          = d[3][5:0];
        @(negedge clk);
        assert (cfg == exp_cfg) else report_mismatch("cfg", exp_cfg, cfg);
        mgmt_select = 1'b1;
        ahb_read({REGS_BASE, 16'h0, REG_STATUS}, 32'h1);
        bus_idle();
        @(negedge clk);
        mgmt_select = 1'b0;
        ahb_read({REGS_BASE, 16'h0, REG_STATUS}, 32'h0);
        bus_idle();
    endtask

    task automatic test_bridge();
        logic [31:0] addr [8];
        logic [31:0] data [8];
        tname = "bridge";
        for (int i = 0; i < 8; i++) begin
            addr[i] = {BRIDGE_BASE, 18'($random(seed)), 4'(i), 2'b00};
            data[i] = $random(seed);
            ahb_write(addr[i], 3'd2, data[i]);
        end
        bus_idle();
        @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            assert (ext_mem[i] == data[i])
                else report_mismatch("bridge wdata", data[i], ext_mem[i]);
        end
        assert (ext_addr == addr[7]) else report_mismatch("ext haddr", addr[7], ext_addr);
        for (int i = 0; i < 8; i++) ahb_read(addr[i], addr[i] ^ 32'hA5A5_0000);
        bus_idle();
    endtask

    task automatic test_unmapped();
        tname = "unmapped";
        ahb_read_err(32'h2100_0000);
        ahb_read_err(32'h3000_0000);
        ahb_write(sram_addr(11'h7FF), 3'd2, 32'h1357_9BDF);
        ahb_read(sram_addr(11'h7FF), 32'h1357_9BDF);
        bus_idle();
    endtask

    initial begin
        arst_n         = 1'b0;
        mgmt_select    = 1'b0;
        ahb_req        = '0;
        ahb_req.hready = 1'b1;
        ext_rsp        = '{hready_resp: 1'b1, hresp: 1'b0, hrdata: '0};
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_sys_regs();  // Reset values first
        test_sram_words();
        test_sram_lanes();
        test_bridge();
        test_unmapped();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/ahbl_sys_pkg.sv
hw/ahbl_splitter.sv
hw/ahbl_sram_ctrl.sv
hw/sys_regs.sv
hw/ahbl_sys0.sv
sim/sram_model.sv
sim/ahbl_sys0_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the AHB-Lite subsystem testbench with Verilator and runs it.
# Exit status is 0 only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module ahbl_sys0_tb -o sim_ahbl_sys0
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ahbl_sys0 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '=== PASS ==='; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
